/* bench/afu_asserts.sv */
/*
 * Handshake assertions for afu_top, bound into every instance of it.
 * Covers memory request stability, AXI response hold and the interrupt
 * state after reset.
 */
`timescale 1ns/1ps
`default_nettype none

module afu_asserts #(
	parameter int NUM_BANKS  = 2,
	parameter int MEM_ADDR_W = 25,
	parameter int MEM_DATA_W = 32
) (
	input wire                            clk,
	input wire                            reset,
	input wire                            core_reset,
	input wire [NUM_BANKS-1:0]            req_valid,
	input wire [NUM_BANKS-1:0]            req_ready,
	input wire [NUM_BANKS*MEM_ADDR_W-1:0] req_addr,
	input wire [NUM_BANKS*MEM_DATA_W-1:0] req_data,
	input wire                            bvalid,
	input wire                            bready,
	input wire                            rvalid,
	input wire                            rready,
	input wire [31:0]                     rdata,
	input wire                            interrupt
);
	logic [NUM_BANKS-1:0]            stall_q;
	logic [NUM_BANKS*MEM_ADDR_W-1:0] addr_q;
	logic [NUM_BANKS*MEM_DATA_W-1:0] data_q;
	logic                            hold_ok;
	int fail_hold = 0;
	int fail_b = 0;
	int fail_r = 0;
	int fail_irq = 0;
	int fail_cnt;

	always @(posedge clk) begin
		stall_q <= reset ? '0 : (req_valid & ~req_ready);
		addr_q  <= req_addr;
		data_q  <= req_data;
	end

	// a bank stalled last cycle must present the same request now
	always_comb begin
		hold_ok = 1'b1;
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (stall_q[b] && (!req_valid[b]
				|| req_addr[b*MEM_ADDR_W +: MEM_ADDR_W] != addr_q[b*MEM_ADDR_W +: MEM_ADDR_W]
				|| req_data[b*MEM_DATA_W +: MEM_DATA_W] != data_q[b*MEM_DATA_W +: MEM_DATA_W]))
				hold_ok = 1'b0;
		end
	end

	assign fail_cnt = fail_hold + fail_b + fail_r + fail_irq;

	assert property (@(posedge clk) disable iff (reset || core_reset) hold_ok)
		else begin fail_hold++; $error("memory request changed while stalled"); end
	assert property (@(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid)
		else begin fail_b++; $error("bvalid dropped before bready"); end
	assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else begin fail_r++; $error("read response not held until rready"); end
	assert property (@(posedge clk) reset |=> !interrupt)
		else begin fail_irq++; $error("interrupt high after reset"); end

endmodule

bind afu_top afu_asserts #(
	.NUM_BANKS  (NUM_BANKS),
	.MEM_ADDR_W (MEM_ADDR_W),
	.MEM_DATA_W (MEM_DATA_W)
) u_asserts (
	.clk        (clk),
	.reset      (reset),
	.core_reset (core_reset),
	.req_valid  (mem_req_valid),
	.req_ready  (mem_req_ready),
	.req_addr   (mem_req_addr),
	.req_data   (mem_req_data),
	.bvalid     (s_axi_ctrl_bvalid),
	.bready     (s_axi_ctrl_bready),
	.rvalid     (s_axi_ctrl_rvalid),
	.rready     (s_axi_ctrl_rready),
	.rdata      (s_axi_ctrl_rdata),
	.interrupt  (interrupt)
);

`default_nettype wire

/* bench/afu_checker.sv */
/*
 * Scoreboard for afu_top. Follows the runs started on the control bus,
 * derives each bank's expected writes from the fill rule, and checks
 * the done, ISR and interrupt behavior against the memory traffic.
 */
`timescale 1ns/1ps
`default_nettype none

module afu_checker #(
	parameter int NUM_BANKS  = 2,
	parameter int MEM_ADDR_W = 25,
	parameter int MEM_DATA_W = 32,
	parameter int MEM_OFFSET = 'h100,
	parameter int STIM_WORDS = 25
) (
	input  wire                             clk,
	input  wire                             reset,
	input  wire                             awvalid,
	input  wire                             awready,
	input  wire                             wready,
	input  wire [afu_pkg::CTRL_ADDR_W-1:0]  awaddr,
	input  wire [afu_pkg::CTRL_DATA_W-1:0]  wdata,
	input  wire                             bvalid,
	input  wire                             bready,
	input  wire [1:0]                       bresp,
	input  wire                             arvalid,
	input  wire                             arready,
	input  wire [afu_pkg::CTRL_ADDR_W-1:0]  araddr,
	input  wire                             rvalid,
	input  wire                             rready,
	input  wire [afu_pkg::CTRL_DATA_W-1:0]  rdata,
	input  wire [1:0]                       rresp,
	input  wire [NUM_BANKS-1:0]             req_valid,
	input  wire [NUM_BANKS-1:0]             req_ready,
	input  wire [NUM_BANKS*MEM_ADDR_W-1:0]  req_addr,
	input  wire [NUM_BANKS*MEM_DATA_W-1:0]  req_data,
	input  wire [NUM_BANKS-1:0]             rsp_valid,
	input  wire                             interrupt,
	input  wire                             run_done,
	output int                              errors
);
	import afu_pkg::*;

	logic [31:0]            stim [0:STIM_WORDS-1];
	logic [31:0]            base = '0;
	logic [31:0]            count = '0;
	logic [31:0]            seed = '0;
	logic [31:0]            flags = '0;
	logic [31:0]            last_ctrl = '0;
	logic [CTRL_ADDR_W-1:0] rd_addr = '0;
	logic                   isr_exp = 1'b0;
	logic                   run_active = 1'b0;
	int                     run_idx = 0;
	int                     bank_n [NUM_BANKS];
	int                     run_acc = 0;
	int                     acc_total = 0;
	int                     rsp_total = 0;
	int                     snap_out = 0;
	int                     snap_acc = 0;

	initial begin
		errors = 0;
		for (int b = 0; b < NUM_BANKS; b++) bank_n[b] = 0;
		$readmemh("bench/afu_stimulus.txt", stim);
	end

	task automatic report(input string msg);
		errors = errors + 1;
		$display("Error at %0t: %s", $time, msg);
	endtask

	always @(posedge clk) begin
		int                    i;
		logic [MEM_ADDR_W-1:0] a_exp;
		logic [MEM_DATA_W-1:0] d_exp;
		if (!reset) begin
			// address and data channels are accepted together
			if (wready !== awready) report("wready and awready differ");
			if (awvalid && awready && awaddr == REG_CTRL && wdata[0] && run_idx < 6) begin
				flags = stim[4*run_idx+4];
				// a seed-only run keeps the previous base and count
				if (!flags[1]) begin
					base  = stim[4*run_idx+1];
					count = stim[4*run_idx+2];
				end
				seed       = stim[4*run_idx+3];
				run_idx    = run_idx + 1;
				run_acc    = 0;
				run_active = 1'b1;
				for (int b = 0; b < NUM_BANKS; b++) bank_n[b] = 0;
			end
			if (awvalid && awready && awaddr == REG_ISR && wdata[0]) isr_exp = 1'b0;
			if (bvalid && bready && bresp != RESP_OKAY) report("write response not OKAY");

			if (rvalid && rready) begin
				if (rresp != RESP_OKAY) report($sformatf("read of 0x%0h not OKAY", rd_addr));
				case (rd_addr)
				REG_CTRL: begin
					last_ctrl = rdata;
					if (rdata[CTRL_DONE_BIT] && snap_out != 0)
						report($sformatf("done read with %0d writes pending", snap_out));
					if (rdata[CTRL_DONE_BIT] && run_active && !flags[2] && snap_acc != count)
						report($sformatf("done after %0d of %0d writes", snap_acc, count));
				end
				REG_ISR: begin
					if (rdata[0] !== isr_exp) report($sformatf("ISR read %0d", rdata[0]));
					if (interrupt !== (isr_exp && flags[0]))
						report($sformatf("interrupt %0b with ISR %0b", interrupt, isr_exp));
				end
				REG_GIE, REG_IER, REG_DCR_ADDR, REG_DCR_DATA: ;
				default: if (rdata !== '0) report($sformatf("offset 0x%0h read 0x%0h",
					rd_addr, rdata));
				endcase
			end
			if (arvalid && arready) begin
				rd_addr  = araddr;
				snap_out = acc_total - rsp_total;
				snap_acc = run_acc;
			end

			if (run_done) begin
				if (flags[2]) begin
					if (!last_ctrl[CTRL_IDLE_BIT]) report("unit not idle after soft reset");
					if (interrupt) report("interrupt raised by a soft-reset run");
				end else begin
					if (run_acc != count)
						report($sformatf("run wrote %0d words, expected %0d", run_acc, count));
					isr_exp = 1'b1;
					if (interrupt !== flags[0]) report("interrupt wrong at end of run");
				end
				run_active = 1'b0;
			end

			for (int b = 0; b < NUM_BANKS; b++) begin
				if (req_valid[b] && req_ready[b]) begin
					i     = bank_n[b] * NUM_BANKS + b;
					a_exp = MEM_ADDR_W'(MEM_OFFSET) + MEM_ADDR_W'(base)
						+ MEM_ADDR_W'(4 * bank_n[b]);
					d_exp = MEM_DATA_W'(seed + 32'(i));
					if (!run_active || i >= int'(count)) begin
						report($sformatf("unexpected write on bank %0d", b));
					end else if (req_addr[b*MEM_ADDR_W +: MEM_ADDR_W] !== a_exp
						|| req_data[b*MEM_DATA_W +: MEM_DATA_W] !== d_exp) begin
						report($sformatf("word %0d bank %0d got 0x%0h/0x%0h, expected 0x%0h/0x%0h",
							i, b, req_addr[b*MEM_ADDR_W +: MEM_ADDR_W],
							req_data[b*MEM_DATA_W +: MEM_DATA_W], a_exp, d_exp));
					end
					bank_n[b] = bank_n[b] + 1;
					run_acc   = run_acc + 1;
					acc_total = acc_total + 1;
				end
				if (rsp_valid[b]) begin
					rsp_total = rsp_total + 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* bench/afu_stimulus.txt */
// first word: number of runs; then one run per line, in hex:
// base  count  seed  flags (bit0 irq enable, bit1 seed only, bit2 soft reset)
00000006
00000000 00000010 00001000 00000001
00000200 00000025 deadbe00 00000000
00000000 00000000 a5a50000 00000003
00000040 00000000 00000077 00000001
00000080 00000030 00005000 00000005
00000010 0000000b 00009000 00000001

/* bench/tb_afu.sv */
/*
 * Testbench for afu_top. Programs each run from the stimulus file over
 * AXI4-Lite, models the banked memory with random stalls and responses,
 * and hands the checking to afu_checker.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_afu;
	import afu_pkg::*;

	localparam int NUM_BANKS   = 2;
	localparam int MEM_ADDR_W  = 25;
	localparam int MEM_DATA_W  = 32;
	localparam int RESET_DELAY = 8;
	localparam int PENDING_W   = 12;
	localparam int MEM_OFFSET  = 'h100;
	localparam int STIM_WORDS  = 25;

	logic                            clk;
	logic                            reset;
	logic                            awvalid;
	logic                            awready;
	logic [CTRL_ADDR_W-1:0]          awaddr;
	logic                            wvalid;
	logic                            wready;
	logic [CTRL_DATA_W-1:0]          wdata;
	logic [CTRL_DATA_W/8-1:0]        wstrb;
	logic                            arvalid;
	logic                            arready;
	logic [CTRL_ADDR_W-1:0]          araddr;
	logic                            rvalid;
	logic                            rready;
	logic [CTRL_DATA_W-1:0]          rdata;
	logic [1:0]                      rresp;
	logic                            bvalid;
	logic                            bready;
	logic [1:0]                      bresp;
	logic [NUM_BANKS-1:0]            mem_req_valid;
	logic [NUM_BANKS-1:0]            mem_req_ready;
	logic [NUM_BANKS*MEM_ADDR_W-1:0] mem_req_addr;
	logic [NUM_BANKS*MEM_DATA_W-1:0] mem_req_data;
	logic [NUM_BANKS-1:0]            mem_rsp_valid;
	logic                            interrupt;
	logic                            run_done;
	int                              check_errors;

	logic [31:0] stim [0:STIM_WORDS-1];
	integer      seed;
	int          cycle;
	int          cycle_limit;
	int          accepted;
	int          due [NUM_BANKS][64];
	int          head [NUM_BANKS];
	int          tail [NUM_BANKS];

	afu_top #(
		.NUM_BANKS   (NUM_BANKS),
		.MEM_ADDR_W  (MEM_ADDR_W),
		.MEM_DATA_W  (MEM_DATA_W),
		.RESET_DELAY (RESET_DELAY),
		.PENDING_W   (PENDING_W),
		.MEM_OFFSET  (MEM_OFFSET)
	) DUT (
		.clk (clk), .reset (reset),
		.s_axi_ctrl_awvalid (awvalid), .s_axi_ctrl_awready (awready),
		.s_axi_ctrl_awaddr (awaddr), .s_axi_ctrl_wvalid (wvalid),
		.s_axi_ctrl_wready (wready), .s_axi_ctrl_wdata (wdata),
		.s_axi_ctrl_wstrb (wstrb), .s_axi_ctrl_arvalid (arvalid),
		.s_axi_ctrl_arready (arready), .s_axi_ctrl_araddr (araddr),
		.s_axi_ctrl_rvalid (rvalid), .s_axi_ctrl_rready (rready),
		.s_axi_ctrl_rdata (rdata), .s_axi_ctrl_rresp (rresp),
		.s_axi_ctrl_bvalid (bvalid), .s_axi_ctrl_bready (bready),
		.s_axi_ctrl_bresp (bresp),
		.mem_req_valid (mem_req_valid), .mem_req_ready (mem_req_ready),
		.mem_req_addr (mem_req_addr), .mem_req_data (mem_req_data),
		.mem_rsp_valid (mem_rsp_valid), .interrupt (interrupt)
	);

	afu_checker #(
		.NUM_BANKS  (NUM_BANKS),
		.MEM_ADDR_W (MEM_ADDR_W),
		.MEM_DATA_W (MEM_DATA_W),
		.MEM_OFFSET (MEM_OFFSET),
		.STIM_WORDS (STIM_WORDS)
	) u_check (
		.clk (clk), .reset (reset),
		.awvalid (awvalid), .awready (awready), .awaddr (awaddr), .wdata (wdata),
		.wready (wready),
		.bvalid (bvalid), .bready (bready), .bresp (bresp),
		.arvalid (arvalid), .arready (arready), .araddr (araddr),
		.rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp),
		.req_valid (mem_req_valid), .req_ready (mem_req_ready),
		.req_addr (mem_req_addr), .req_data (mem_req_data),
		.rsp_valid (mem_rsp_valid), .interrupt (interrupt),
		.run_done (run_done), .errors (check_errors)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic axi_write(input logic [CTRL_ADDR_W-1:0] addr, input logic [31:0] data);
		awaddr  <= addr;
		wdata   <= data;
		wstrb   <= 4'hf;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		@(posedge clk);
		while (!awready) @(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		bready  <= 1'b1;
		@(posedge clk);
		while (!bvalid) @(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [CTRL_ADDR_W-1:0] addr, output logic [31:0] data);
		araddr  <= addr;
		arvalid <= 1'b1;
		@(posedge clk);
		while (!arready) @(posedge clk);
		arvalid <= 1'b0;
		rready  <= 1'b1;
		@(posedge clk);
		while (!rvalid) @(posedge clk);
		data = rdata;
		rready <= 1'b0;
	endtask

	task automatic dcr_write(input logic [DCR_ADDR_W-1:0] addr, input logic [31:0] data);
		axi_write(REG_DCR_ADDR, 32'(addr));
		axi_write(REG_DCR_DATA, data);
	endtask

	// flags: bit0 interrupt enable, bit1 rewrite seed only, bit2 soft reset mid-run
	task automatic program_and_run(input int r);
		logic [31:0] flags;
		logic [31:0] rd;
		int          mark;
		flags = stim[4*r+4];
		axi_write(REG_GIE, 32'h1);
		axi_write(REG_IER, {31'b0, flags[0]});
		if (!flags[1]) begin
			dcr_write(DCR_BASE, stim[4*r+1]);
			dcr_write(DCR_COUNT, stim[4*r+2]);
		end
		dcr_write(DCR_SEED, stim[4*r+3]);
		mark = accepted;
		axi_write(REG_CTRL, 32'h1);
		if (flags[2]) begin
			while (accepted - mark < 8) @(posedge clk);
			axi_write(REG_CTRL, 32'h2);
		end
		rd = '0;
		while (!rd[CTRL_DONE_BIT]) axi_read(REG_CTRL, rd);
		run_done <= 1'b1;
		@(posedge clk);
		run_done <= 1'b0;
		axi_read(REG_ISR, rd);
		axi_write(REG_ISR, 32'h1);
		axi_read(REG_ISR, rd);
	endtask

	// bank memory: random ready, in-order responses 1 to 6 cycles after acceptance
	always @(posedge clk) begin
		logic [NUM_BANKS-1:0] rsp_next;
		logic [NUM_BANKS-1:0] ready_next;
		rsp_next   = '0;
		ready_next = '0;
		if (!reset) begin
			for (int b = 0; b < NUM_BANKS; b++) begin
				if (head[b] != tail[b] && due[b][head[b] % 64] <= cycle) begin
					rsp_next[b] = 1'b1;
					head[b]     = head[b] + 1;
				end
				if (mem_req_valid[b] && mem_req_ready[b]) begin
					due[b][tail[b] % 64] = cycle + 1 + ({$random(seed)} % 6);
					tail[b]  = tail[b] + 1;
					accepted = accepted + 1;
				end
				ready_next[b] = (({$random(seed)} % 4) != 0);
			end
		end
		mem_rsp_valid <= rsp_next;
		mem_req_ready <= ready_next;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= cycle_limit) begin
			$display("Timeout: test did not complete within %0d cycles", cycle_limit);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		logic [31:0] rd;
		int          n_runs;
		int          words;
		int          count;
		int          assert_fails;
		reset         = 1'b1;
		awvalid       = 1'b0;
		awaddr        = '0;
		wvalid        = 1'b0;
		wdata         = '0;
		wstrb         = '0;
		arvalid       = 1'b0;
		araddr        = '0;
		bready        = 1'b0;
		rready        = 1'b0;
		mem_req_ready = '0;
		mem_rsp_valid = '0;
		run_done      = 1'b0;
		seed          = 32'h7918_9d1d;
		cycle         = 0;
		accepted      = 0;
		for (int b = 0; b < NUM_BANKS; b++) begin
			head[b] = 0;
			tail[b] = 0;
		end
		$readmemh("bench/afu_stimulus.txt", stim);
		n_runs = (stim[0] > 6) ? 6 : int'(stim[0]);
		words  = 0;
		count  = 0;
		for (int r = 0; r < n_runs; r++) begin
			if (!stim[4*r+4][1]) begin
				count = stim[4*r+2];
			end
			words = words + count;
		end
		cycle_limit = 200 + 20 * words;

		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		// unmapped offsets
		axi_read(8'h1C, rd);
		axi_read(8'h40, rd);
		for (int r = 0; r < n_runs; r++) begin
			program_and_run(r);
		end
		repeat (4) @(posedge clk);

		assert_fails = DUT.u_asserts.fail_cnt;
		$display("checks done: %0d checker errors, %0d assertion failures",
			check_errors, assert_fails);
		if (check_errors == 0 && assert_fails == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* design/afu_ctrl.sv */
/*
 * AXI4-Lite control slave. Holds the interrupt registers and the DCR
 * address/data pair, turns CTRL writes into start and soft reset pulses
 * and reports done/idle back to the host.
 */
`timescale 1ns/1ps
`default_nettype none

module afu_ctrl (
	input  wire                             clk,
	input  wire                             reset,

	input  wire                             s_axi_awvalid,
	input  wire [afu_pkg::CTRL_ADDR_W-1:0]  s_axi_awaddr,
	input  wire                             s_axi_wvalid,
	input  wire [afu_pkg::CTRL_DATA_W-1:0]  s_axi_wdata,
	input  wire [afu_pkg::CTRL_DATA_W/8-1:0] s_axi_wstrb,
	input  wire                             s_axi_arvalid,
	input  wire [afu_pkg::CTRL_ADDR_W-1:0]  s_axi_araddr,
	input  wire                             s_axi_bready,
	input  wire                             s_axi_rready,
	output logic                            s_axi_awready,
	output logic                            s_axi_wready,
	output logic                            s_axi_arready,
	output logic                            s_axi_rvalid,
	output logic [afu_pkg::CTRL_DATA_W-1:0] s_axi_rdata,
	output logic [1:0]                      s_axi_rresp,
	output logic                            s_axi_bvalid,
	output logic [1:0]                      s_axi_bresp,

	input  wire                             ap_done,
	input  wire                             ap_idle,
	output logic                            ap_start,
	output logic                            ap_reset,
	output logic                            interrupt,

	output logic                            dcr_wr_valid,
	output logic [afu_pkg::DCR_ADDR_W-1:0]  dcr_wr_addr,
	output logic [afu_pkg::DCR_DATA_W-1:0]  dcr_wr_data
);
	import afu_pkg::*;

	logic                   wr_fire;
	logic                   rd_fire;
	logic [CTRL_DATA_W-1:0] wmask;
	logic [CTRL_DATA_W-1:0] rd_value;
	logic                   gie;
	logic                   ier;
	logic                   isr;
	logic                   armed;
	logic                   done_q;
	logic                   done_rise;

	// write address and data are taken together, one transaction at a time
	assign wr_fire       = s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid;
	assign s_axi_awready = wr_fire;
	assign s_axi_wready  = wr_fire;
	assign s_axi_bresp   = RESP_OKAY;

	assign s_axi_arready = !s_axi_rvalid;
	assign rd_fire       = s_axi_arvalid && s_axi_arready;
	assign s_axi_rresp   = RESP_OKAY;

	always_comb begin
		for (int i = 0; i < CTRL_DATA_W/8; i++) begin
			wmask[i*8 +: 8] = {8{s_axi_wstrb[i]}};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s_axi_bvalid <= 1'b0;
			s_axi_rvalid <= 1'b0;
		end else begin
			if (wr_fire) begin
				s_axi_bvalid <= 1'b1;
			end else if (s_axi_bready) begin
				s_axi_bvalid <= 1'b0;
			end
			if (rd_fire) begin
				s_axi_rvalid <= 1'b1;
			end else if (s_axi_rready) begin
				s_axi_rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ap_start     <= 1'b0;
			ap_reset     <= 1'b0;
			dcr_wr_valid <= 1'b0;
		end else begin
			ap_start <= wr_fire && (s_axi_awaddr == REG_CTRL) && s_axi_wstrb[0]
				&& s_axi_wdata[CTRL_START_BIT];
			ap_reset <= wr_fire && (s_axi_awaddr == REG_CTRL) && s_axi_wstrb[0]
				&& s_axi_wdata[CTRL_SRST_BIT];
			dcr_wr_valid <= wr_fire && (s_axi_awaddr == REG_DCR_DATA);
		end
	end

	// DCR pair, byte lanes merged under wstrb
	always_ff @(posedge clk) begin
		if (wr_fire && (s_axi_awaddr == REG_DCR_ADDR)) begin
			dcr_wr_addr <= DCR_ADDR_W'((CTRL_DATA_W'(dcr_wr_addr) & ~wmask)
				| (s_axi_wdata & wmask));
		end
		if (wr_fire && (s_axi_awaddr == REG_DCR_DATA)) begin
			dcr_wr_data <= DCR_DATA_W'((CTRL_DATA_W'(dcr_wr_data) & ~wmask)
				| (s_axi_wdata & wmask));
		end
	end

	// done only counts once per start
	assign done_rise = armed && ap_done && !done_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			gie    <= 1'b0;
			ier    <= 1'b0;
			isr    <= 1'b0;
			armed  <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= ap_done;
			if (wr_fire && (s_axi_awaddr == REG_GIE) && s_axi_wstrb[0]) begin
				gie <= s_axi_wdata[0];
			end
			if (wr_fire && (s_axi_awaddr == REG_IER) && s_axi_wstrb[0]) begin
				ier <= s_axi_wdata[0];
			end
			if (done_rise) begin
				isr <= 1'b1;
			end else if (wr_fire && (s_axi_awaddr == REG_ISR) && s_axi_wstrb[0]
				&& s_axi_wdata[0]) begin
				isr <= 1'b0;
			end
			if (ap_reset || done_rise) begin
				armed <= 1'b0;
			end else if (ap_start) begin
				armed <= 1'b1;
			end
		end
	end

	assign interrupt = gie && ier && isr;

	always_comb begin
		rd_value = '0;
		case (s_axi_araddr)
		REG_CTRL: begin
			rd_value[CTRL_DONE_BIT] = ap_done;
			rd_value[CTRL_IDLE_BIT] = ap_idle;
		end
		REG_GIE:      rd_value = CTRL_DATA_W'(gie);
		REG_IER:      rd_value = CTRL_DATA_W'(ier);
		REG_ISR:      rd_value = CTRL_DATA_W'(isr);
		REG_DCR_ADDR: rd_value = CTRL_DATA_W'(dcr_wr_addr);
		REG_DCR_DATA: rd_value = CTRL_DATA_W'(dcr_wr_data);
		default:      rd_value = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			s_axi_rdata <= rd_value;
		end
	end

endmodule

`default_nettype wire

/* design/afu_pkg.sv */
/*
 * Shared constants for the accelerator wrapper: control bus widths,
 * control register offsets, DCR addresses and the AXI response code.
 * Imported by the RTL and by the testbench.
 */
`default_nettype none

package afu_pkg;

	localparam int CTRL_ADDR_W = 8;
	localparam int CTRL_DATA_W = 32;
	localparam int DCR_ADDR_W  = 12;
	localparam int DCR_DATA_W  = 32;

	// control register map
	localparam logic [CTRL_ADDR_W-1:0] REG_CTRL     = 8'h00;
	localparam logic [CTRL_ADDR_W-1:0] REG_GIE      = 8'h04;
	localparam logic [CTRL_ADDR_W-1:0] REG_IER      = 8'h08;
	localparam logic [CTRL_ADDR_W-1:0] REG_ISR      = 8'h0C;
	localparam logic [CTRL_ADDR_W-1:0] REG_DCR_ADDR = 8'h10;
	localparam logic [CTRL_ADDR_W-1:0] REG_DCR_DATA = 8'h14;

	// REG_CTRL bits, write side and read side
	localparam int CTRL_START_BIT = 0;
	localparam int CTRL_SRST_BIT  = 1;
	localparam int CTRL_DONE_BIT  = 1;
	localparam int CTRL_IDLE_BIT  = 2;

	// device configuration registers of the fill core
	localparam logic [DCR_ADDR_W-1:0] DCR_BASE  = 12'h001;
	localparam logic [DCR_ADDR_W-1:0] DCR_COUNT = 12'h002;
	localparam logic [DCR_ADDR_W-1:0] DCR_SEED  = 12'h003;

	localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

/* design/afu_run_seq.sv */
/*
 * Run sequencer. Holds the core in reset for RESET_DELAY cycles after a
 * start, then waits for the core to go busy and idle again. Done is
 * reported once no memory writes are pending.
 */
`timescale 1ns/1ps
`default_nettype none

module afu_run_seq #(
	parameter int RESET_DELAY = 8
) (
	input  wire  clk,
	input  wire  reset,
	input  wire  ap_start,
	input  wire  ap_reset,
	input  wire  busy,
	input  wire  pending_zero,
	output logic core_reset,
	output logic ap_done
);
	localparam int CTR_W = $clog2(RESET_DELAY + 1);

	typedef enum logic {
		S_IDLE,
		S_RUN
	} state_t;

	state_t           state;
	logic [CTR_W-1:0] delay_ctr;
	logic             busy_wait;

	always_ff @(posedge clk) begin
		if (reset || ap_reset) begin
			state      <= S_IDLE;
			core_reset <= 1'b1;
			delay_ctr  <= '0;
			busy_wait  <= 1'b0;
		end else begin
			case (state)
			S_IDLE: begin
				if (ap_start) begin
					state      <= S_RUN;
					core_reset <= 1'b1;
					delay_ctr  <= CTR_W'(RESET_DELAY - 1);
				end
			end
			S_RUN: begin
				if (core_reset) begin
					if (delay_ctr == '0) begin
						core_reset <= 1'b0;
						busy_wait  <= 1'b1;
					end else begin
						delay_ctr <= delay_ctr - 1'b1;
					end
				end else if (busy_wait) begin
					// core has not started yet
					if (busy) begin
						busy_wait <= 1'b0;
					end
				end else if (!busy) begin
					state <= S_IDLE;
				end
			end
			default: state <= S_IDLE;
			endcase
		end
	end

	assign ap_done = (state == S_IDLE) && pending_zero;

endmodule

`default_nettype wire

/* design/afu_top.sv */
/*
 * Accelerator top level. Connects the AXI4-Lite control slave, the run
 * sequencer, the write tracker and the fill core; all parameters are
 * set here and passed down.
 */
`timescale 1ns/1ps
`default_nettype none

module afu_top #(
	parameter int NUM_BANKS   = 2,
	parameter int MEM_ADDR_W  = 25,
	parameter int MEM_DATA_W  = 32,
	parameter int RESET_DELAY = 8,
	parameter int PENDING_W   = 12,
	parameter int MEM_OFFSET  = 'h100
) (
	input  wire                             clk,
	input  wire                             reset,

	input  wire                             s_axi_ctrl_awvalid,
	output logic                            s_axi_ctrl_awready,
	input  wire [afu_pkg::CTRL_ADDR_W-1:0]  s_axi_ctrl_awaddr,
	input  wire                             s_axi_ctrl_wvalid,
	output logic                            s_axi_ctrl_wready,
	input  wire [afu_pkg::CTRL_DATA_W-1:0]  s_axi_ctrl_wdata,
	input  wire [afu_pkg::CTRL_DATA_W/8-1:0] s_axi_ctrl_wstrb,
	input  wire                             s_axi_ctrl_arvalid,
	output logic                            s_axi_ctrl_arready,
	input  wire [afu_pkg::CTRL_ADDR_W-1:0]  s_axi_ctrl_araddr,
	output logic                            s_axi_ctrl_rvalid,
	input  wire                             s_axi_ctrl_rready,
	output logic [afu_pkg::CTRL_DATA_W-1:0] s_axi_ctrl_rdata,
	output logic [1:0]                      s_axi_ctrl_rresp,
	output logic                            s_axi_ctrl_bvalid,
	input  wire                             s_axi_ctrl_bready,
	output logic [1:0]                      s_axi_ctrl_bresp,

	output logic [NUM_BANKS-1:0]            mem_req_valid,
	input  wire [NUM_BANKS-1:0]             mem_req_ready,
	output logic [NUM_BANKS*MEM_ADDR_W-1:0] mem_req_addr,
	output logic [NUM_BANKS*MEM_DATA_W-1:0] mem_req_data,
	input  wire [NUM_BANKS-1:0]             mem_rsp_valid,

	output logic                            interrupt
);
	import afu_pkg::*;

	logic                  ap_start;
	logic                  ap_reset;
	logic                  ap_done;
	logic                  core_reset;
	logic                  busy;
	logic                  pending_zero;
	logic                  dcr_wr_valid;
	logic [DCR_ADDR_W-1:0] dcr_wr_addr;
	logic [DCR_DATA_W-1:0] dcr_wr_data;

	afu_ctrl u_ctrl (
		.clk           (clk),
		.reset         (reset),
		.s_axi_awvalid (s_axi_ctrl_awvalid),
		.s_axi_awaddr  (s_axi_ctrl_awaddr),
		.s_axi_wvalid  (s_axi_ctrl_wvalid),
		.s_axi_wdata   (s_axi_ctrl_wdata),
		.s_axi_wstrb   (s_axi_ctrl_wstrb),
		.s_axi_arvalid (s_axi_ctrl_arvalid),
		.s_axi_araddr  (s_axi_ctrl_araddr),
		.s_axi_bready  (s_axi_ctrl_bready),
		.s_axi_rready  (s_axi_ctrl_rready),
		.s_axi_awready (s_axi_ctrl_awready),
		.s_axi_wready  (s_axi_ctrl_wready),
		.s_axi_arready (s_axi_ctrl_arready),
		.s_axi_rvalid  (s_axi_ctrl_rvalid),
		.s_axi_rdata   (s_axi_ctrl_rdata),
		.s_axi_rresp   (s_axi_ctrl_rresp),
		.s_axi_bvalid  (s_axi_ctrl_bvalid),
		.s_axi_bresp   (s_axi_ctrl_bresp),
		.ap_done       (ap_done),
		// core held in reset means the unit is idle
		.ap_idle       (core_reset),
		.ap_start      (ap_start),
		.ap_reset      (ap_reset),
		.interrupt     (interrupt),
		.dcr_wr_valid  (dcr_wr_valid),
		.dcr_wr_addr   (dcr_wr_addr),
		.dcr_wr_data   (dcr_wr_data)
	);

	afu_run_seq #(
		.RESET_DELAY (RESET_DELAY)
	) u_run_seq (
		.clk          (clk),
		.reset        (reset),
		.ap_start     (ap_start),
		.ap_reset     (ap_reset),
		.busy         (busy),
		.pending_zero (pending_zero),
		.core_reset   (core_reset),
		.ap_done      (ap_done)
	);

	write_tracker #(
		.NUM_BANKS (NUM_BANKS),
		.PENDING_W (PENDING_W)
	) u_tracker (
		.clk          (clk),
		.reset        (reset),
		.req_valid    (mem_req_valid),
		.req_ready    (mem_req_ready),
		.rsp_fire     (mem_rsp_valid),
		.pending_zero (pending_zero)
	);

	fill_engine #(
		.NUM_BANKS  (NUM_BANKS),
		.MEM_ADDR_W (MEM_ADDR_W),
		.MEM_DATA_W (MEM_DATA_W),
		.MEM_OFFSET (MEM_OFFSET)
	) u_core (
		.clk           (clk),
		.core_reset    (core_reset),
		.dcr_wr_valid  (dcr_wr_valid),
		.dcr_wr_addr   (dcr_wr_addr),
		.dcr_wr_data   (dcr_wr_data),
		.mem_req_ready (mem_req_ready),
		.mem_req_valid (mem_req_valid),
		.mem_req_addr  (mem_req_addr),
		.mem_req_data  (mem_req_data),
		.busy          (busy)
	);

endmodule

`default_nettype wire

/* design/fill_engine.sv */
/*
 * Fill core. Writes SEED + i for words 0 to COUNT-1, interleaved over the
 * banks word by word, each bank through a one-entry request slot.
 * The DCRs are written at any time and survive core_reset.
 */
`timescale 1ns/1ps
`default_nettype none

module fill_engine #(
	parameter int NUM_BANKS  = 2,
	parameter int MEM_ADDR_W = 25,
	parameter int MEM_DATA_W = 32,
	parameter int MEM_OFFSET = 'h100
) (
	input  wire                            clk,
	input  wire                            core_reset,
	input  wire                            dcr_wr_valid,
	input  wire [afu_pkg::DCR_ADDR_W-1:0]  dcr_wr_addr,
	input  wire [afu_pkg::DCR_DATA_W-1:0]  dcr_wr_data,
	input  wire [NUM_BANKS-1:0]            mem_req_ready,
	output logic [NUM_BANKS-1:0]           mem_req_valid,
	output logic [NUM_BANKS*MEM_ADDR_W-1:0] mem_req_addr,
	output logic [NUM_BANKS*MEM_DATA_W-1:0] mem_req_data,
	output logic                           busy
);
	import afu_pkg::*;

	localparam int BANK_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

	logic [DCR_DATA_W-1:0] dcr_base;
	logic [DCR_DATA_W-1:0] dcr_count;
	logic [DCR_DATA_W-1:0] dcr_seed;
	logic                  go;
	logic [DCR_DATA_W-1:0] word_idx;
	logic [DCR_DATA_W-1:0] line_idx;
	logic [BANK_W-1:0]     bank_sel;
	logic [NUM_BANKS-1:0]  req_fire;
	logic [NUM_BANKS-1:0]  load;
	logic                  words_left;
	logic                  issue;
	logic                  slots_drain;
	logic [MEM_ADDR_W-1:0] next_addr;
	logic [MEM_DATA_W-1:0] next_data;

	always_ff @(posedge clk) begin
		if (dcr_wr_valid) begin
			case (dcr_wr_addr)
			DCR_BASE:  dcr_base  <= dcr_wr_data;
			DCR_COUNT: dcr_count <= dcr_wr_data;
			DCR_SEED:  dcr_seed  <= dcr_wr_data;
			default:   ;
			endcase
		end
	end

	assign req_fire   = mem_req_valid & mem_req_ready;
	assign words_left = (word_idx != dcr_count);

	// a slot can be refilled in the cycle its request is taken
	assign issue = busy && words_left
		&& (!mem_req_valid[bank_sel] || mem_req_ready[bank_sel]);
	assign slots_drain = ((mem_req_valid & ~mem_req_ready) == '0);

	assign next_addr = MEM_ADDR_W'(MEM_OFFSET) + MEM_ADDR_W'(dcr_base)
		+ MEM_ADDR_W'(line_idx << 2);
	assign next_data = MEM_DATA_W'(dcr_seed + word_idx);

	always_comb begin
		load           = '0;
		load[bank_sel] = issue;
	end

	always_ff @(posedge clk) begin
		if (core_reset) begin
			go       <= 1'b1;
			busy     <= 1'b0;
			word_idx <= '0;
			line_idx <= '0;
			bank_sel <= '0;
		end else begin
			if (go) begin
				go   <= 1'b0;
				busy <= 1'b1;
			end else if (busy && !words_left && slots_drain) begin
				busy <= 1'b0;
			end
			if (issue) begin
				word_idx <= word_idx + 1'b1;
				if (bank_sel == BANK_W'(NUM_BANKS - 1)) begin
					bank_sel <= '0;
					line_idx <= line_idx + 1'b1;
				end else begin
					bank_sel <= bank_sel + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (core_reset) begin
			mem_req_valid <= '0;
		end else begin
			mem_req_valid <= (mem_req_valid & ~req_fire) | load;
		end
	end

	always_ff @(posedge clk) begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (load[b]) begin
				mem_req_addr[b*MEM_ADDR_W +: MEM_ADDR_W] <= next_addr;
				mem_req_data[b*MEM_DATA_W +: MEM_DATA_W] <= next_data;
			end
		end
	end

endmodule

`default_nettype wire

/* design/write_tracker.sv */
/*
 * Outstanding write counter over all memory banks. Each cycle adds the
 * number of accepted requests and subtracts the number of responses.
 */
`timescale 1ns/1ps
`default_nettype none

module write_tracker #(
	parameter int NUM_BANKS = 2,
	parameter int PENDING_W = 12
) (
	input  wire                 clk,
	input  wire                 reset,
	input  wire [NUM_BANKS-1:0] req_valid,
	input  wire [NUM_BANKS-1:0] req_ready,
	input  wire [NUM_BANKS-1:0] rsp_fire,
	output logic                pending_zero
);
	localparam int CNT_W = $clog2(NUM_BANKS + 1);

	logic [NUM_BANKS-1:0] req_fire;
	logic [CNT_W-1:0]     req_cnt;
	logic [CNT_W-1:0]     rsp_cnt;
	logic [PENDING_W-1:0] pending;

	function automatic logic [CNT_W-1:0] popcount(input logic [NUM_BANKS-1:0] v);
		logic [CNT_W-1:0] n;
		n = '0;
		for (int i = 0; i < NUM_BANKS; i++) begin
			n = n + CNT_W'(v[i]);
		end
		return n;
	endfunction

	assign req_fire = req_valid & req_ready;
	assign req_cnt  = popcount(req_fire);
	assign rsp_cnt  = popcount(rsp_fire);

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= '0;
		end else begin
			pending <= pending + PENDING_W'(req_cnt) - PENDING_W'(rsp_cnt);
		end
	end

	assign pending_zero = (pending == '0);

endmodule

`default_nettype wire

/* sources.f */
design/afu_pkg.sv
design/afu_ctrl.sv
design/afu_run_seq.sv
design/write_tracker.sv
design/fill_engine.sv
design/afu_top.sv
bench/afu_asserts.sv
bench/afu_checker.sv
bench/tb_afu.sv
